/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - logic/decode_pkg.sv
      - logic/inst_decoder.sv
      - logic/operand_forward.sv
      - logic/branch_resolve.sv
      - logic/id_ex_reg.sv
      - logic/decode_stage.sv
  - target: test
    files:
      - testbench/decode_stage_assertions.sv
      - testbench/decode_stage_tb.sv

/* files.f */
+incdir+include
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
testbench/decode_stage_assertions.sv
testbench/decode_stage_tb.sv

/* include/mips_opcodes.svh */
`ifndef MIPS_OPCODES_SVH
`define MIPS_OPCODES_SVH

//////////////////////////////////////////////////////////////////////
// Instruction field codes
//////////////////////////////////////////////////////////////////////

localparam opcode_t OP_SPECIAL = 6'b000000;
localparam opcode_t OP_REGIMM  = 6'b000001;
localparam opcode_t OP_J       = 6'b000010;
localparam opcode_t OP_JAL     = 6'b000011;
localparam opcode_t OP_BEQ     = 6'b000100;
localparam opcode_t OP_BNE     = 6'b000101;
localparam opcode_t OP_BLEZ    = 6'b000110;
localparam opcode_t OP_BGTZ    = 6'b000111;
localparam opcode_t OP_ADDI    = 6'b001000;
localparam opcode_t OP_ADDIU   = 6'b001001;
localparam opcode_t OP_SLTI    = 6'b001010;
localparam opcode_t OP_SLTIU   = 6'b001011;
localparam opcode_t OP_ANDI    = 6'b001100;
localparam opcode_t OP_ORI     = 6'b001101;
localparam opcode_t OP_XORI    = 6'b001110;
localparam opcode_t OP_LUI     = 6'b001111;

// SPECIAL function field, bits 5:0
localparam funct_t FN_SLL  = 6'b000000;
localparam funct_t FN_SRL  = 6'b000010;
localparam funct_t FN_SRA  = 6'b000011;
localparam funct_t FN_SLLV = 6'b000100;
localparam funct_t FN_SRLV = 6'b000110;
localparam funct_t FN_SRAV = 6'b000111;
localparam funct_t FN_JR   = 6'b001000;
localparam funct_t FN_JALR = 6'b001001;
localparam funct_t FN_ADD  = 6'b100000;
localparam funct_t FN_ADDU = 6'b100001;
localparam funct_t FN_SUB  = 6'b100010;
localparam funct_t FN_SUBU = 6'b100011;
localparam funct_t FN_AND  = 6'b100100;
localparam funct_t FN_OR   = 6'b100101;
localparam funct_t FN_XOR  = 6'b100110;
localparam funct_t FN_NOR  = 6'b100111;
localparam funct_t FN_SLT  = 6'b101010;
localparam funct_t FN_SLTU = 6'b101011;

// REGIMM rt field
localparam reg_addr_t RT_BLTZ   = 5'b00000;
localparam reg_addr_t RT_BGEZ   = 5'b00001;
localparam reg_addr_t RT_BLTZAL = 5'b10000;
localparam reg_addr_t RT_BGEZAL = 5'b10001;

//////////////////////////////////////////////////////////////////////
// Execute stage operation codes
//////////////////////////////////////////////////////////////////////

localparam alu_op_t ALU_NOP    = 8'b00000000;
localparam alu_op_t ALU_AND    = 8'b00100100;
localparam alu_op_t ALU_OR     = 8'b00100101;
localparam alu_op_t ALU_XOR    = 8'b00100110;
localparam alu_op_t ALU_NOR    = 8'b00100111;
localparam alu_op_t ALU_SLL    = 8'b01111100;
localparam alu_op_t ALU_SRL    = 8'b00000010;
localparam alu_op_t ALU_SRA    = 8'b00000011;
localparam alu_op_t ALU_SLT    = 8'b00101010;
localparam alu_op_t ALU_SLTU   = 8'b00101011;
localparam alu_op_t ALU_ADD    = 8'b00100000;
localparam alu_op_t ALU_ADDU   = 8'b00100001;
localparam alu_op_t ALU_SUB    = 8'b00100010;
localparam alu_op_t ALU_SUBU   = 8'b00100011;
localparam alu_op_t ALU_ADDI   = 8'b01010101;
localparam alu_op_t ALU_ADDIU  = 8'b01010110;
localparam alu_op_t ALU_J      = 8'b01001111;
localparam alu_op_t ALU_JAL    = 8'b01010000;
localparam alu_op_t ALU_JR     = 8'b00001000;
localparam alu_op_t ALU_JALR   = 8'b00001001;
localparam alu_op_t ALU_BEQ    = 8'b01010001;
localparam alu_op_t ALU_BNE    = 8'b01010010;
localparam alu_op_t ALU_BLEZ   = 8'b01010011;
localparam alu_op_t ALU_BGTZ   = 8'b01010100;
localparam alu_op_t ALU_BLTZ   = 8'b01000000;
localparam alu_op_t ALU_BGEZ   = 8'b01000001;
localparam alu_op_t ALU_BLTZAL = 8'b01001010;
localparam alu_op_t ALU_BGEZAL = 8'b01001011;

// Result group seen by execute
localparam alu_sel_t SEL_NOP   = 3'b000;
localparam alu_sel_t SEL_LOGIC = 3'b001;
localparam alu_sel_t SEL_SHIFT = 3'b010;
localparam alu_sel_t SEL_ARITH = 3'b100;
localparam alu_sel_t SEL_JUMP  = 3'b110;

`endif

/* logic/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve import decode_pkg::*; (
	input  branch_kind_t branch_kind_i,
	input  logic         link_i,
	input  word_t        pc_i,
	input  word_t        inst_i,
	input  word_t        reg1_i,
	input  word_t        reg2_i,
	output logic         branch_flag_o,
	output word_t        branch_target_o,
	output word_t        link_addr_o
);

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t offset;
	word_t jump_target;
	logic reg1_zero;
	logic taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;
	assign offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};	// Same 256 MB region
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		case (branch_kind_i)
			BR_J, BR_JR: taken = 1'b1;
			BR_EQ:  taken = (reg1_i == reg2_i);
			BR_NE:  taken = (reg1_i != reg2_i);
			BR_GTZ: taken = !reg1_i[31] && !reg1_zero;
			BR_LEZ: taken = reg1_i[31] || reg1_zero;
			BR_GEZ: taken = !reg1_i[31];
			BR_LTZ: taken = reg1_i[31];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (!taken) begin
			branch_target_o = '0;
		end else if (branch_kind_i == BR_J) begin
			branch_target_o = jump_target;
		end else if (branch_kind_i == BR_JR) begin
			branch_target_o = reg1_i;
		end else begin
			branch_target_o = pc_plus_4 + offset;
		end
	end

	assign branch_flag_o = taken;
	assign link_addr_o = link_i ? pc_plus_8 : '0;	// Return past the delay slot

endmodule

/* logic/decode_pkg.sv */
package decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;	// Bits 31:26
	typedef logic [5:0] funct_t;	// Bits 5:0 of SPECIAL
	typedef logic [7:0] alu_op_t;
	typedef logic [2:0] alu_sel_t;
	typedef logic [3:0] branch_kind_t;

	`include "mips_opcodes.svh"

	// JAL and the AL branches link here
	localparam reg_addr_t LINK_REG = 5'd31;

	// Control transfer kinds
	localparam branch_kind_t BR_NONE = 4'd0;
	localparam branch_kind_t BR_J    = 4'd1;	// Absolute index
	localparam branch_kind_t BR_JR   = 4'd2;	// Target from rs
	localparam branch_kind_t BR_EQ   = 4'd3;
	localparam branch_kind_t BR_NE   = 4'd4;
	localparam branch_kind_t BR_GTZ  = 4'd5;
	localparam branch_kind_t BR_LEZ  = 4'd6;
	localparam branch_kind_t BR_GEZ  = 4'd7;
	localparam branch_kind_t BR_LTZ  = 4'd8;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output logic      reg1_read_o,
	output reg_addr_t reg1_addr_o,
	output logic      reg2_read_o,
	output reg_addr_t reg2_addr_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output alu_op_t   ex_aluop_o,
	output alu_sel_t  ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_link_addr_o,
	output logic      ex_is_in_delayslot_o
);

	alu_op_t aluop;
	alu_sel_t alusel;
	reg_addr_t wd;
	logic wreg;
	word_t imm;
	branch_kind_t branch_kind;
	logic link;
	word_t reg1;
	word_t reg2;
	word_t link_addr;

	// Register file always addressed by rs and rt
	assign reg1_addr_o = inst_i[25:21];
	assign reg2_addr_o = inst_i[20:16];

	inst_decoder u_dec (
		.inst_i(inst_i),
		.aluop_o(aluop), .alusel_o(alusel),
		.reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
		.wd_o(wd), .wreg_o(wreg),
		.imm_o(imm),
		.branch_kind_o(branch_kind), .link_o(link)
	);

	//////////////////////////////////////////////////////////////////////
	// Operand fetch with bypass from execute and memory
	operand_forward u_fwd1 (
		.read_i(reg1_read_o), .addr_i(reg1_addr_o),
		.reg_data_i(reg1_data_i), .imm_i(imm),
		.ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
		.mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
		.operand_o(reg1)
	);

	operand_forward u_fwd2 (
		.read_i(reg2_read_o), .addr_i(reg2_addr_o),
		.reg_data_i(reg2_data_i), .imm_i(imm),
		.ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
		.mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
		.operand_o(reg2)
	);

	//////////////////////////////////////////////////////////////////////
	// Branch decision back to fetch, then the execute register
	branch_resolve u_br (
		.branch_kind_i(branch_kind), .link_i(link),
		.pc_i(pc_i), .inst_i(inst_i),
		.reg1_i(reg1), .reg2_i(reg2),
		.branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.link_addr_o(link_addr)
	);

	id_ex_reg u_id_ex (
		.clk_i(clk_i), .rst_i(rst_i),
		.aluop_i(aluop), .alusel_i(alusel),
		.reg1_i(reg1), .reg2_i(reg2),
		.wd_i(wd), .wreg_i(wreg),
		.link_addr_i(link_addr),
		.branch_flag_i(branch_flag_o),
		.ex_aluop_o(ex_aluop_o), .ex_alusel_o(ex_alusel_o),
		.ex_reg1_o(ex_reg1_o), .ex_reg2_o(ex_reg2_o),
		.ex_wd_o(ex_wd_o), .ex_wreg_o(ex_wreg_o),
		.ex_link_addr_o(ex_link_addr_o),
		.ex_is_in_delayslot_o(ex_is_in_delayslot_o)
	);

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import decode_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  alu_op_t   aluop_i,
	input  alu_sel_t  alusel_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  word_t     link_addr_i,
	input  logic      branch_flag_i,
	output alu_op_t   ex_aluop_o,
	output alu_sel_t  ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_link_addr_o,
	output logic      ex_is_in_delayslot_o
);

	logic next_in_delayslot;	// Instruction now in decode follows a taken branch

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ex_aluop_o <= ALU_NOP;
			ex_alusel_o <= SEL_NOP;
			ex_reg1_o <= '0;
			ex_reg2_o <= '0;
			ex_wd_o <= '0;
			ex_wreg_o <= 1'b0;
			ex_link_addr_o <= '0;
			ex_is_in_delayslot_o <= 1'b0;
			next_in_delayslot <= 1'b0;
		end else begin
			ex_aluop_o <= aluop_i;
			ex_alusel_o <= alusel_i;
			ex_reg1_o <= reg1_i;
			ex_reg2_o <= reg2_i;
			ex_wd_o <= wd_i;
			ex_wreg_o <= wreg_i;
			ex_link_addr_o <= link_addr_i;
			ex_is_in_delayslot_o <= next_in_delayslot;
			next_in_delayslot <= branch_flag_i;
		end
	end

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
	input  word_t        inst_i,
	output alu_op_t      aluop_o,
	output alu_sel_t     alusel_o,
	output logic         reg1_read_o,
	output logic         reg2_read_o,
	output reg_addr_t    wd_o,
	output logic         wreg_o,
	output word_t        imm_o,
	output branch_kind_t branch_kind_o,
	output logic         link_o
);

	opcode_t opcode;
	funct_t funct;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t sa;
	logic [15:0] imm16;
	word_t imm_zext;
	word_t imm_sext;
	word_t imm_upper;

	assign opcode = inst_i[31:26];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign sa = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	assign imm_zext = {16'h0000, imm16};
	assign imm_sext = {{16{imm16[15]}}, imm16};
	assign imm_upper = {imm16, 16'h0000};

	always_comb begin
		// Anything unmatched stays a NOP with no write
		aluop_o = ALU_NOP;
		alusel_o = SEL_NOP;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		wd_o = rd;
		wreg_o = 1'b0;
		imm_o = '0;
		branch_kind_o = BR_NONE;
		link_o = 1'b0;

		case (opcode)
			//////////////////////////////////////////////////////////////////////
			// R-type
			OP_SPECIAL: begin
				case (funct)
					FN_AND:  {alusel_o, aluop_o} = {SEL_LOGIC, ALU_AND};
					FN_OR:   {alusel_o, aluop_o} = {SEL_LOGIC, ALU_OR};
					FN_XOR:  {alusel_o, aluop_o} = {SEL_LOGIC, ALU_XOR};
					FN_NOR:  {alusel_o, aluop_o} = {SEL_LOGIC, ALU_NOR};
					FN_SLL:  {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SLL};
					FN_SRL:  {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SRL};
					FN_SRA:  {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SRA};
					FN_SLLV: {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SLL};
					FN_SRLV: {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SRL};
					FN_SRAV: {alusel_o, aluop_o} = {SEL_SHIFT, ALU_SRA};
					FN_ADD:  {alusel_o, aluop_o} = {SEL_ARITH, ALU_ADD};
					FN_ADDU: {alusel_o, aluop_o} = {SEL_ARITH, ALU_ADDU};
					FN_SUB:  {alusel_o, aluop_o} = {SEL_ARITH, ALU_SUB};
					FN_SUBU: {alusel_o, aluop_o} = {SEL_ARITH, ALU_SUBU};
					FN_SLT:  {alusel_o, aluop_o} = {SEL_ARITH, ALU_SLT};
					FN_SLTU: {alusel_o, aluop_o} = {SEL_ARITH, ALU_SLTU};
					FN_JR:   {alusel_o, aluop_o} = {SEL_JUMP, ALU_JR};
					FN_JALR: {alusel_o, aluop_o} = {SEL_JUMP, ALU_JALR};
					default: begin
					end
				endcase
				if (alusel_o != SEL_NOP) begin
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
					wreg_o = 1'b1;
				end
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						reg1_read_o = 1'b0;	// Shift amount in place of rs
						imm_o = {27'd0, sa};
					end
					FN_JR: begin
						reg2_read_o = 1'b0;
						wreg_o = 1'b0;
						branch_kind_o = BR_JR;
					end
					FN_JALR: begin
						reg2_read_o = 1'b0;
						branch_kind_o = BR_JR;
						link_o = 1'b1;	// Link goes to rd
					end
					default: begin
					end
				endcase
			end

			//////////////////////////////////////////////////////////////////////
			// Immediate ALU forms, result to rt
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				reg1_read_o = 1'b1;
				wd_o = rt;
				wreg_o = 1'b1;
				case (opcode)
					OP_ANDI:  {alusel_o, aluop_o, imm_o} = {SEL_LOGIC, ALU_AND, imm_zext};
					OP_ORI:   {alusel_o, aluop_o, imm_o} = {SEL_LOGIC, ALU_OR, imm_zext};
					OP_XORI:  {alusel_o, aluop_o, imm_o} = {SEL_LOGIC, ALU_XOR, imm_zext};
					OP_LUI:   {alusel_o, aluop_o, imm_o} = {SEL_LOGIC, ALU_OR, imm_upper};
					OP_ADDI:  {alusel_o, aluop_o, imm_o} = {SEL_ARITH, ALU_ADDI, imm_sext};
					OP_ADDIU: {alusel_o, aluop_o, imm_o} = {SEL_ARITH, ALU_ADDIU, imm_sext};
					OP_SLTI:  {alusel_o, aluop_o, imm_o} = {SEL_ARITH, ALU_SLT, imm_sext};
					OP_SLTIU: {alusel_o, aluop_o, imm_o} = {SEL_ARITH, ALU_SLTU, imm_sext};
					default: begin
					end
				endcase
			end

			//////////////////////////////////////////////////////////////////////
			// Jumps and branches
			OP_J: begin
				{alusel_o, aluop_o} = {SEL_JUMP, ALU_J};
				branch_kind_o = BR_J;
			end
			OP_JAL: begin
				{alusel_o, aluop_o} = {SEL_JUMP, ALU_JAL};
				branch_kind_o = BR_J;
				link_o = 1'b1;
				wd_o = LINK_REG;
				wreg_o = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				alusel_o = SEL_JUMP;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				{aluop_o, branch_kind_o} = (opcode == OP_BEQ) ? {ALU_BEQ, BR_EQ} : {ALU_BNE, BR_NE};
			end
			OP_BGTZ, OP_BLEZ: begin
				alusel_o = SEL_JUMP;
				reg1_read_o = 1'b1;
				{aluop_o, branch_kind_o} = (opcode == OP_BGTZ) ? {ALU_BGTZ, BR_GTZ} : {ALU_BLEZ, BR_LEZ};
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ:   {aluop_o, branch_kind_o} = {ALU_BLTZ, BR_LTZ};
					RT_BGEZ:   {aluop_o, branch_kind_o} = {ALU_BGEZ, BR_GEZ};
					RT_BLTZAL: {aluop_o, branch_kind_o} = {ALU_BLTZAL, BR_LTZ};
					RT_BGEZAL: {aluop_o, branch_kind_o} = {ALU_BGEZAL, BR_GEZ};
					default: begin
					end
				endcase
				if (branch_kind_o != BR_NONE) begin
					alusel_o = SEL_JUMP;
					reg1_read_o = 1'b1;
				end
				// Link forms write r31 taken or not
				if (rt == RT_BLTZAL || rt == RT_BGEZAL) begin
					link_o = 1'b1;
					wd_o = LINK_REG;
					wreg_o = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

/* logic/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     reg_data_i,
	input  word_t     imm_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output word_t     operand_o
);

	// Youngest result wins, so execute beats memory
	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_wreg_i && (ex_wd_i == addr_i)) begin
			operand_o = ex_wdata_i;
		end else if (mem_wreg_i && (mem_wd_i == addr_i)) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

/* testbench/decode_stage_assertions.sv */
`timescale 1ns/1ps

module decode_stage_assertions (
	input logic       clk_i,
	input logic       rst_i,
	input logic       branch_flag_i,
	input logic       ex_wreg_i,
	input logic [4:0] ex_wd_i,
	input logic       ex_delayslot_i
);

	int fail_count = 0;	// Failed assertions so far

	// First cycle out of reset still shows the cleared register
	assert property (@(posedge clk_i) $fell(rst_i) |-> !ex_wreg_i)
		else begin
			$error("execute write enable high right after reset");
			fail_count++;
		end

	// Taken flag is stored once, then tags the following instruction
	assert property (@(posedge clk_i) disable iff (rst_i)
		(!$past(rst_i, 1) && !$past(rst_i, 2)) |->
		(ex_delayslot_i == $past(branch_flag_i, 2)))
		else begin
			$error("delay-slot flag does not follow the taken branch");
			fail_count++;
		end

	assert property (@(posedge clk_i) ex_wreg_i |-> !$isunknown(ex_wd_i))
		else begin
			$error("destination unknown while write is enabled");
			fail_count++;
		end

endmodule

bind decode_stage decode_stage_assertions u_assert (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.branch_flag_i(branch_flag_o),
	.ex_wreg_i(ex_wreg_o),
	.ex_wd_i(ex_wd_o),
	.ex_delayslot_i(ex_is_in_delayslot_o)
);

/* testbench/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

	localparam int N_ROWS = 55;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT = RESET_CYCLES + N_ROWS + 20;
	localparam logic [1:0] SRC_RF = 2'd0;
	localparam logic [1:0] SRC_EX = 2'd1;
	localparam logic [1:0] SRC_MEM = 2'd2;
	localparam logic [1:0] SRC_IMM = 2'd3;

	logic clk_i;
	logic rst_i;
	word_t pc_i, inst_i, reg1_data_i, reg2_data_i;
	logic ex_wreg_i, mem_wreg_i;
	reg_addr_t ex_wd_i, mem_wd_i;
	word_t ex_wdata_i, mem_wdata_i;
	logic reg1_read_o, reg2_read_o, branch_flag_o;
	reg_addr_t reg1_addr_o, reg2_addr_o, ex_wd_o;
	word_t branch_target_o, ex_reg1_o, ex_reg2_o, ex_link_addr_o;
	alu_op_t ex_aluop_o;
	alu_sel_t ex_alusel_o;
	logic ex_wreg_o, ex_is_in_delayslot_o;

	// Stimulus and expected values, one row per instruction
	string t_name[N_ROWS];
	word_t t_inst[N_ROWS], t_pc[N_ROWS], t_d1[N_ROWS], t_d2[N_ROWS], t_imm[N_ROWS];
	logic t_exw[N_ROWS], t_memw[N_ROWS], t_fixed[N_ROWS];
	reg_addr_t t_exwd[N_ROWS], t_memwd[N_ROWS], t_wd[N_ROWS];
	logic t_rd1[N_ROWS], t_rd2[N_ROWS], t_wreg[N_ROWS], t_flag[N_ROWS];
	logic [1:0] t_src1[N_ROWS], t_src2[N_ROWS];
	alu_op_t t_aluop[N_ROWS];
	alu_sel_t t_alusel[N_ROWS];
	word_t t_target[N_ROWS], t_link[N_ROWS];
	word_t r1d[N_ROWS], r2d[N_ROWS], exd[N_ROWS], memd[N_ROWS];	// Data actually driven
	int n_rows;
	int cycles;
	word_t rng;

	decode_stage decode_stage_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$fatal(1, "simulation timed out");
		end else if (decode_stage_i.u_assert.fail_count != 0) begin
			$display("A bound assertion on the DUT did not hold");
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t r_inst(input funct_t fn, input int rs, rt, rd, sa);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
	endfunction

	function automatic word_t i_inst(input opcode_t op, input int rs, rt, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t j_inst(input opcode_t op, input logic [25:0] index);
		return {op, index};
	endfunction

	function automatic word_t pick(input logic [1:0] src, input word_t rf, ex, mem, imm);
		case (src)
			SRC_EX: return ex;
			SRC_MEM: return mem;
			SRC_IMM: return imm;
			default: return rf;
		endcase
	endfunction

	task automatic check_value(input string test, what, input word_t exp, act);
		if (exp !== act) begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input string name, input word_t inst, pc, input logic rd1, rd2,
			input logic [1:0] src1, src2, input word_t imm, input alu_op_t op,
			input alu_sel_t sel, input int wd, input logic wreg);
		t_name[n_rows] = name;
		t_inst[n_rows] = inst;
		t_pc[n_rows] = pc;
		{t_rd1[n_rows], t_rd2[n_rows], t_src1[n_rows], t_src2[n_rows]} = {rd1, rd2, src1, src2};
		{t_imm[n_rows], t_aluop[n_rows], t_alusel[n_rows]} = {imm, op, sel};
		t_wd[n_rows] = 5'(wd);
		t_wreg[n_rows] = wreg;
		{t_exw[n_rows], t_exwd[n_rows], t_memw[n_rows], t_memwd[n_rows]} = '0;
		{t_fixed[n_rows], t_d1[n_rows], t_d2[n_rows]} = '0;
		{t_flag[n_rows], t_target[n_rows], t_link[n_rows]} = '0;
		n_rows++;
	endtask

	// Modifiers for the row added last
	task automatic set_fwd(input logic exw, input int exwd, input logic memw, input int memwd);
		{t_exw[n_rows-1], t_exwd[n_rows-1]} = {exw, 5'(exwd)};
		{t_memw[n_rows-1], t_memwd[n_rows-1]} = {memw, 5'(memwd)};
	endtask

	task automatic set_data(input word_t d1, d2);
		{t_fixed[n_rows-1], t_d1[n_rows-1], t_d2[n_rows-1]} = {1'b1, d1, d2};
	endtask

	task automatic set_branch(input logic flag, input word_t target, link);
		{t_flag[n_rows-1], t_target[n_rows-1], t_link[n_rows-1]} = {flag, target, link};
	endtask

	task automatic build_table();
		word_t pc;
		pc = 32'h0000_1000;
		//////////////////////////////////////////////////////////////////////
		// ALU instructions
		add_row("or", r_inst(FN_OR, 1, 2, 3, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_OR, SEL_LOGIC, 3, 1);
		add_row("and", r_inst(FN_AND, 4, 5, 6, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_AND, SEL_LOGIC, 6, 1);
		add_row("xor", r_inst(FN_XOR, 7, 8, 9, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_XOR, SEL_LOGIC, 9, 1);
		add_row("nor", r_inst(FN_NOR, 10, 11, 12, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_NOR, SEL_LOGIC, 12, 1);
		add_row("sll", r_inst(FN_SLL, 0, 2, 3, 5), pc,
			0, 1, SRC_IMM, SRC_RF, 5, ALU_SLL, SEL_SHIFT, 3, 1);
		add_row("srl", r_inst(FN_SRL, 0, 4, 5, 31), pc,
			0, 1, SRC_IMM, SRC_RF, 31, ALU_SRL, SEL_SHIFT, 5, 1);
		add_row("sra", r_inst(FN_SRA, 0, 6, 7, 7), pc,
			0, 1, SRC_IMM, SRC_RF, 7, ALU_SRA, SEL_SHIFT, 7, 1);
		add_row("sllv", r_inst(FN_SLLV, 1, 2, 3, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SLL, SEL_SHIFT, 3, 1);
		add_row("srlv", r_inst(FN_SRLV, 1, 2, 4, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SRL, SEL_SHIFT, 4, 1);
		add_row("srav", r_inst(FN_SRAV, 1, 2, 5, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SRA, SEL_SHIFT, 5, 1);
		add_row("add", r_inst(FN_ADD, 1, 2, 13, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_ADD, SEL_ARITH, 13, 1);
		add_row("addu", r_inst(FN_ADDU, 3, 4, 14, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_ADDU, SEL_ARITH, 14, 1);
		add_row("sub", r_inst(FN_SUB, 5, 6, 15, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SUB, SEL_ARITH, 15, 1);
		add_row("subu", r_inst(FN_SUBU, 7, 8, 16, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SUBU, SEL_ARITH, 16, 1);
		add_row("slt", r_inst(FN_SLT, 9, 10, 17, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SLT, SEL_ARITH, 17, 1);
		add_row("sltu", r_inst(FN_SLTU, 11, 12, 18, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_SLTU, SEL_ARITH, 18, 1);
		add_row("ori", i_inst(OP_ORI, 1, 2, 16'h8001), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h0000_8001, ALU_OR, SEL_LOGIC, 2, 1);
		add_row("andi", i_inst(OP_ANDI, 1, 3, 16'hF0F0), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h0000_F0F0, ALU_AND, SEL_LOGIC, 3, 1);
		add_row("xori", i_inst(OP_XORI, 1, 4, 16'hFFFF), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h0000_FFFF, ALU_XOR, SEL_LOGIC, 4, 1);
		add_row("lui", i_inst(OP_LUI, 0, 3, 16'h1234), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h1234_0000, ALU_OR, SEL_LOGIC, 3, 1);
		add_row("addi", i_inst(OP_ADDI, 2, 5, 16'h8000), pc,
			1, 0, SRC_RF, SRC_IMM, 32'hFFFF_8000, ALU_ADDI, SEL_ARITH, 5, 1);
		add_row("addiu", i_inst(OP_ADDIU, 2, 6, 16'h7FFF), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h0000_7FFF, ALU_ADDIU, SEL_ARITH, 6, 1);
		add_row("slti", i_inst(OP_SLTI, 2, 7, 16'hFFFE), pc,
			1, 0, SRC_RF, SRC_IMM, 32'hFFFF_FFFE, ALU_SLT, SEL_ARITH, 7, 1);
		add_row("sltiu", i_inst(OP_SLTIU, 2, 8, 16'h0010), pc,
			1, 0, SRC_RF, SRC_IMM, 32'h10, ALU_SLTU, SEL_ARITH, 8, 1);
		//////////////////////////////////////////////////////////////////////
		// Forwarding priority
		add_row("fwd_ex_mem", r_inst(FN_ADD, 6, 7, 8, 0), pc,
			1, 1, SRC_EX, SRC_RF, 0, ALU_ADD, SEL_ARITH, 8, 1);
		set_fwd(1, 6, 1, 6);
		add_row("fwd_mem", r_inst(FN_ADD, 6, 7, 8, 0), pc,
			1, 1, SRC_RF, SRC_MEM, 0, ALU_ADD, SEL_ARITH, 8, 1);
		set_fwd(1, 9, 1, 7);
		add_row("fwd_ex_rt", r_inst(FN_ADD, 3, 4, 8, 0), pc,
			1, 1, SRC_RF, SRC_EX, 0, ALU_ADD, SEL_ARITH, 8, 1);
		set_fwd(1, 4, 0, 0);
		add_row("fwd_imm", i_inst(OP_ORI, 5, 6, 16'h00AA), pc,
			1, 0, SRC_RF, SRC_IMM, 32'hAA, ALU_OR, SEL_LOGIC, 6, 1);
		set_fwd(1, 6, 1, 6);
		add_row("fwd_off", r_inst(FN_ADD, 6, 6, 8, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_ADD, SEL_ARITH, 8, 1);
		set_fwd(0, 6, 0, 6);
		//////////////////////////////////////////////////////////////////////
		// Jumps
		add_row("j", j_inst(OP_J, 26'h40), 32'h1000_0070,
			0, 0, SRC_IMM, SRC_IMM, 0, ALU_J, SEL_JUMP, 0, 0);
		set_branch(1, 32'h1000_0100, 0);
		add_row("slot_ori", i_inst(OP_ORI, 1, 2, 16'h0001), pc,
			1, 0, SRC_RF, SRC_IMM, 1, ALU_OR, SEL_LOGIC, 2, 1);
		add_row("jal", j_inst(OP_JAL, 26'h3FF_FFFF), 32'hF000_0000,
			0, 0, SRC_IMM, SRC_IMM, 0, ALU_JAL, SEL_JUMP, 31, 1);
		set_branch(1, 32'hFFFF_FFFC, 32'hF000_0008);
		add_row("slot_nop", 32'h0, pc,
			0, 1, SRC_IMM, SRC_RF, 0, ALU_SLL, SEL_SHIFT, 0, 1);
		add_row("jr", r_inst(FN_JR, 9, 0, 0, 0), pc,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_JR, SEL_JUMP, 0, 0);
		set_data(32'h0040_1234, 32'h0);
		set_branch(1, 32'h0040_1234, 0);
		add_row("jalr", r_inst(FN_JALR, 10, 0, 5, 0), 32'h2000,
			1, 0, SRC_EX, SRC_IMM, 0, ALU_JALR, SEL_JUMP, 5, 1);
		set_fwd(1, 10, 0, 0);
		set_data(32'h1111, 32'h0080_0040);
		set_branch(1, 32'h0080_0040, 32'h2008);
		//////////////////////////////////////////////////////////////////////
		// Conditional branches
		add_row("beq_t", i_inst(OP_BEQ, 1, 2, 16'h0010), 32'h3000,
			1, 1, SRC_RF, SRC_RF, 0, ALU_BEQ, SEL_JUMP, 0, 0);
		set_data(5, 5);
		set_branch(1, 32'h3044, 0);
		add_row("beq_n", i_inst(OP_BEQ, 1, 2, 16'h0010), 32'h3000,
			1, 1, SRC_RF, SRC_RF, 0, ALU_BEQ, SEL_JUMP, 0, 0);
		set_data(5, 6);
		add_row("bne_t", i_inst(OP_BNE, 1, 2, 16'hFFF0), 32'h3008,
			1, 1, SRC_RF, SRC_RF, 0, ALU_BNE, SEL_JUMP, 0, 0);
		set_data(5, 6);
		set_branch(1, 32'h2FCC, 0);
		add_row("bne_n", i_inst(OP_BNE, 1, 2, 16'hFFF0), 32'h3008,
			1, 1, SRC_RF, SRC_RF, 0, ALU_BNE, SEL_JUMP, 0, 0);
		set_data(7, 7);
		add_row("bgtz_t", i_inst(OP_BGTZ, 3, 0, 16'h0004), 32'h4000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGTZ, SEL_JUMP, 0, 0);
		set_data(1, 0);
		set_branch(1, 32'h4014, 0);
		add_row("bgtz_zero", i_inst(OP_BGTZ, 3, 0, 16'h0004), 32'h4000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGTZ, SEL_JUMP, 0, 0);
		set_data(0, 0);
		add_row("blez_zero", i_inst(OP_BLEZ, 3, 0, 16'h0004), 32'h4000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLEZ, SEL_JUMP, 0, 0);
		set_data(0, 0);
		set_branch(1, 32'h4014, 0);
		add_row("blez_neg", i_inst(OP_BLEZ, 3, 0, 16'h0004), 32'h4000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLEZ, SEL_JUMP, 0, 0);
		set_data(32'h8000_0000, 0);
		set_branch(1, 32'h4014, 0);
		add_row("blez_n", i_inst(OP_BLEZ, 3, 0, 16'h0004), 32'h4000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLEZ, SEL_JUMP, 0, 0);
		set_data(1, 0);
		add_row("bgez_t", i_inst(OP_REGIMM, 4, RT_BGEZ, 16'h0008), 32'h5000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGEZ, SEL_JUMP, 0, 0);
		set_data(0, 0);
		set_branch(1, 32'h5024, 0);
		add_row("bgez_n", i_inst(OP_REGIMM, 4, RT_BGEZ, 16'h0008), 32'h5000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGEZ, SEL_JUMP, 0, 0);
		set_data(32'hFFFF_FFFF, 0);
		add_row("bltz_t", i_inst(OP_REGIMM, 4, RT_BLTZ, 16'h0008), 32'h5000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLTZ, SEL_JUMP, 0, 0);
		set_data(32'hFFFF_FFFF, 0);
		set_branch(1, 32'h5024, 0);
		add_row("bltz_n", i_inst(OP_REGIMM, 4, RT_BLTZ, 16'h0008), 32'h5000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLTZ, SEL_JUMP, 0, 0);
		set_data(0, 0);
		add_row("bgezal_t", i_inst(OP_REGIMM, 4, RT_BGEZAL, 16'h0008), 32'h6000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGEZAL, SEL_JUMP, 31, 1);
		set_data(5, 0);
		set_branch(1, 32'h6024, 32'h6008);
		add_row("bgezal_n", i_inst(OP_REGIMM, 4, RT_BGEZAL, 16'h0008), 32'h6000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BGEZAL, SEL_JUMP, 31, 1);
		set_data(32'h8000_0000, 0);
		set_branch(0, 0, 32'h6008);
		add_row("bltzal_t", i_inst(OP_REGIMM, 4, RT_BLTZAL, 16'h0008), 32'h6000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLTZAL, SEL_JUMP, 31, 1);
		set_data(32'h8000_0000, 0);
		set_branch(1, 32'h6024, 32'h6008);
		add_row("bltzal_n", i_inst(OP_REGIMM, 4, RT_BLTZAL, 16'h0008), 32'h6000,
			1, 0, SRC_RF, SRC_IMM, 0, ALU_BLTZAL, SEL_JUMP, 31, 1);
		set_data(0, 0);
		set_branch(0, 0, 32'h6008);
		// rs comes from execute, which holds the same value as rt
		add_row("beq_fwd", i_inst(OP_BEQ, 1, 2, 16'h0010), 32'h3000,
			1, 1, SRC_EX, SRC_RF, 0, ALU_BEQ, SEL_JUMP, 0, 0);
		set_fwd(1, 1, 0, 0);
		set_data(5, 6);
		set_branch(1, 32'h3044, 0);
		add_row("unknown_op", 32'hFC43_1234, pc,
			0, 0, SRC_IMM, SRC_IMM, 0, ALU_NOP, SEL_NOP, 0, 0);
		add_row("after_unknown", r_inst(FN_OR, 1, 2, 3, 0), pc,
			1, 1, SRC_RF, SRC_RF, 0, ALU_OR, SEL_LOGIC, 3, 1);
	endtask

	task automatic drive_row(input int k);
		word_t a, b, c, d;
		rng = xorshift(rng);
		a = rng;
		rng = xorshift(rng);
		b = rng;
		rng = xorshift(rng);
		c = rng;
		rng = xorshift(rng);
		d = rng;
		if (t_fixed[k]) begin
			a = t_d1[k];
			b = t_d2[k];
			c = t_d2[k];	// Execute result equals rt data
		end
		{r1d[k], r2d[k], exd[k], memd[k]} = {a, b, c, d};
		pc_i <= t_pc[k];
		inst_i <= t_inst[k];
		reg1_data_i <= a;
		reg2_data_i <= b;
		ex_wreg_i <= t_exw[k];
		ex_wd_i <= t_exwd[k];
		ex_wdata_i <= c;
		mem_wreg_i <= t_memw[k];
		mem_wd_i <= t_memwd[k];
		mem_wdata_i <= d;
	endtask

	task automatic check_comb(input int k);
		check_value(t_name[k], "reg1_read", 32'(t_rd1[k]), 32'(reg1_read_o));
		check_value(t_name[k], "reg2_read", 32'(t_rd2[k]), 32'(reg2_read_o));
		check_value(t_name[k], "reg1_addr", 32'(t_inst[k][25:21]), 32'(reg1_addr_o));
		check_value(t_name[k], "reg2_addr", 32'(t_inst[k][20:16]), 32'(reg2_addr_o));
		check_value(t_name[k], "branch_flag", 32'(t_flag[k]), 32'(branch_flag_o));
		check_value(t_name[k], "branch_target", t_target[k], branch_target_o);
	endtask

	task automatic check_registered(input int k, input logic prev_flag);
		word_t op1, op2;
		op1 = pick(t_src1[k], r1d[k], exd[k], memd[k], t_imm[k]);
		op2 = pick(t_src2[k], r2d[k], exd[k], memd[k], t_imm[k]);
		check_value(t_name[k], "ex_aluop", 32'(t_aluop[k]), 32'(ex_aluop_o));
		check_value(t_name[k], "ex_alusel", 32'(t_alusel[k]), 32'(ex_alusel_o));
		check_value(t_name[k], "ex_reg1", op1, ex_reg1_o);
		check_value(t_name[k], "ex_reg2", op2, ex_reg2_o);
		check_value(t_name[k], "ex_wreg", 32'(t_wreg[k]), 32'(ex_wreg_o));
		if (t_wreg[k])
			check_value(t_name[k], "ex_wd", 32'(t_wd[k]), 32'(ex_wd_o));
		check_value(t_name[k], "ex_link_addr", t_link[k], ex_link_addr_o);
		check_value(t_name[k], "ex_delayslot", 32'(prev_flag), 32'(ex_is_in_delayslot_o));
	endtask

	initial begin
		rst_i = 1'b1;
		{pc_i, inst_i, reg1_data_i, reg2_data_i} = '0;
		{ex_wreg_i, ex_wd_i, ex_wdata_i} = '0;
		{mem_wreg_i, mem_wd_i, mem_wdata_i} = '0;
		rng = 32'd94429;
		n_rows = 0;
		cycles = 0;
		build_table();

		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_value("reset", "ex_aluop", 32'(ALU_NOP), 32'(ex_aluop_o));
		check_value("reset", "ex_alusel", 32'(SEL_NOP), 32'(ex_alusel_o));
		check_value("reset", "ex_wreg", 0, 32'(ex_wreg_o));
		check_value("reset", "ex_reg1", 0, ex_reg1_o);
		check_value("reset", "ex_reg2", 0, ex_reg2_o);
		check_value("reset", "ex_wd", 0, 32'(ex_wd_o));
		check_value("reset", "ex_link_addr", 0, ex_link_addr_o);
		check_value("reset", "ex_delayslot", 0, 32'(ex_is_in_delayslot_o));

		for (int k = 0; k < n_rows; k++) begin
			@(posedge clk_i);
			drive_row(k);
			@(negedge clk_i);
			check_comb(k);
			if (k > 0)
				check_registered(k - 1, (k > 1) ? t_flag[k-2] : 1'b0);
		end
		@(posedge clk_i);
		inst_i <= '0;
		ex_wreg_i <= 1'b0;
		mem_wreg_i <= 1'b0;
		@(negedge clk_i);
		check_registered(n_rows - 1, t_flag[n_rows-2]);

		// Bound assertions may have fired on the last edge
		if (decode_stage_i.u_assert.fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
